// File: flist.f
src/ifetch_pkg.sv
src/fetch_ifs.sv
src/fetch_unit.sv
src/icache.sv
src/instr_mem.sv
src/ifetch_top.sv
tb/ifetch_tb.sv

// File: Makefile
# Verilator build and run of the instruction-fetch testbench.

VERILATOR ?= verilator
TOP       ?= ifetch_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# The run passes only if the log holds the pass line.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: program.hex
// one 32-bit instruction word per line, starting at word address 0.
00ff0013
01fe0013
02fd0013
03fc0013
04fb0013
05fa0013
06f90013
07f80013
08f70013
09f60013
0af50013
0bf40013
0cf30013
0df20013
0ef10013
0ff00013
10ef0013
11ee0013
12ed0013
13ec0013
14eb0013
15ea0013
16e90013
17e80013
18e70013
19e60013
1ae50013
1be40013
1ce30013
1de20013
1ee10013
1fe00013
20df0013
21de0013
22dd0013
23dc0013
24db0013
25da0013
26d90013
27d80013
28d70013
29d60013
2ad50013
2bd40013
2cd30013
2dd20013
2ed10013
2fd00013
30cf0013
31ce0013
32cd0013
33cc0013
34cb0013
35ca0013
36c90013
37c80013
38c70013
39c60013
3ac50013
3bc40013
3cc30013
3dc20013
3ec10013
3fc00013

// File: tb/ifetch_tb.sv
module ifetch_tb;

    localparam int lines       = ifetch_pkg::default_lines;
    localparam int mem_words   = ifetch_pkg::default_mem_words;
    localparam int mem_latency = ifetch_pkg::default_mem_latency;
    localparam int n_entries   = 11;
    localparam int hit_gap     = 2; // consecutive hits pulse instr_valid this many cycles apart.

    typedef struct packed {
        int                            count;    // instructions to observe.
        bit                            redirect; // pulse a redirect after the last one.
        logic [ifetch_pkg::addr_w-1:0] target;
        bit                            all_hits; // every pulse must follow the previous by hit_gap.
    } entry_t;

    logic                          clk;
    logic                          rst;
    logic                          redirect_valid;
    logic [ifetch_pkg::addr_w-1:0] redirect_pc;
    logic                          instr_valid;
    logic [ifetch_pkg::addr_w-1:0] instr_pc;
    logic [ifetch_pkg::data_w-1:0] instr;

    logic [ifetch_pkg::data_w-1:0] ref_rom [mem_words];
    entry_t                        stim [n_entries];
    int                            cycle_count = 0;
    int                            cycle_limit = 0;

    ifetch_top #(
        .lines       (lines),
        .mem_words   (mem_words),
        .mem_latency (mem_latency)
    ) ifetch_top_inst (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .instr_valid    (instr_valid),
        .instr_pc       (instr_pc),
        .instr          (instr)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    initial
    begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit)
            @(posedge clk);
        $display("timeout after %0d cycles, the instruction stream stalled", cycle_count);
        $display("test failed");
        $fatal(1);
    end

    function automatic entry_t make_entry(input int count, input bit redirect,
                                          input logic [ifetch_pkg::addr_w-1:0] target,
                                          input bit all_hits);
        entry_t e;
        e.count    = count;
        e.redirect = redirect;
        e.target   = target;
        e.all_hits = all_hits;
        return e;
    endfunction

    // steps the pc by one word and wraps at the end of the rom.
    function automatic logic [ifetch_pkg::addr_w-1:0] step_pc(
        input logic [ifetch_pkg::addr_w-1:0] pc);
        return (pc + 32'd4) % 32'(mem_words * 4);
    endfunction

    function automatic logic [ifetch_pkg::data_w-1:0] expected_word(
        input logic [ifetch_pkg::addr_w-1:0] pc);
        int idx;
        idx = int'((pc >> 2) % 32'(mem_words));
        return ref_rom[idx];
    endfunction

    task automatic check_addr(input string name, input logic [ifetch_pkg::addr_w-1:0] expected,
                              input logic [ifetch_pkg::addr_w-1:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_word(input string name, input logic [ifetch_pkg::data_w-1:0] expected,
                              input logic [ifetch_pkg::data_w-1:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_gap(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // returns at the edge that samples the next instr_valid pulse.
    task automatic wait_instr(output int seen_at);
        @(posedge clk);
        redirect_valid <= 1'b0;
        while (instr_valid !== 1'b1)
            @(posedge clk);
        seen_at = cycle_count;
    endtask

    initial
    begin
        int                            total;
        int                            seen_at;
        int                            last_at;
        logic [ifetch_pkg::addr_w-1:0] exp_pc;
        logic [ifetch_pkg::addr_w-1:0] jump_pc;
        logic [ifetch_pkg::addr_w-1:0] rand_pc;
        bit                            jump_next;

        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        $readmemh("program.hex", ref_rom);
        void'($urandom(10049));
        rand_pc = 32'(int'($urandom % 32'(mem_words)) * 4);

        stim[0]  = make_entry(12, 1'b1, 32'h0000_0040, 1'b0); // cold misses from reset.
        stim[1]  = make_entry(4,  1'b1, 32'h0000_0040, 1'b0);
        stim[2]  = make_entry(4,  1'b1, 32'h0000_0040, 1'b0);
        stim[3]  = make_entry(4,  1'b1, 32'h0000_0040, 1'b1); // loop 0x40..0x4c runs from cache.
        stim[4]  = make_entry(4,  1'b1, 32'h0000_0008, 1'b1);
        stim[5]  = make_entry(2,  1'b1, 32'h0000_0028, 1'b0); // 0x08 and 0x28 share index 2.
        stim[6]  = make_entry(2,  1'b1, 32'h0000_0008, 1'b0);
        stim[7]  = make_entry(2,  1'b1, 32'h0000_0028, 1'b0);
        stim[8]  = make_entry(2,  1'b1, 32'h0000_00f2, 1'b0); // byte offset is dropped.
        stim[9]  = make_entry(8,  1'b1, rand_pc, 1'b0);       // runs past the last word.
        stim[10] = make_entry(10, 1'b0, '0, 1'b0);

        total = 0;
        foreach (stim[e])
            total += stim[e].count;
        cycle_limit = total * (mem_latency + 3) + 200;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        exp_pc    = '0;
        jump_pc   = '0;
        jump_next = 1'b0;
        last_at   = 0;
        for (int e = 0; e < n_entries; e++)
        begin
            for (int k = 0; k < stim[e].count; k++)
            begin
                wait_instr(seen_at);
                check_addr("instr_pc", exp_pc, instr_pc);
                check_word("instr", expected_word(exp_pc), instr);
                if (stim[e].all_hits)
                    check_gap("instr_valid spacing", hit_gap, seen_at - last_at);
                last_at = seen_at;
                if (jump_next)
                begin
                    exp_pc    = jump_pc; // the fetch in flight was delivered first.
                    jump_next = 1'b0;
                end
                else
                    exp_pc = step_pc(exp_pc);
            end
            if (stim[e].redirect)
            begin
                redirect_valid <= 1'b1;
                redirect_pc    <= stim[e].target;
                jump_pc         = stim[e].target & ~32'h0000_0003;
                jump_next       = 1'b1;
            end
        end

        $display("test passed");
        $finish;
    end

endmodule

// File: src/ifetch_top.sv
module ifetch_top #(
    parameter int lines       = ifetch_pkg::default_lines,
    parameter int mem_words   = ifetch_pkg::default_mem_words,
    parameter int mem_latency = ifetch_pkg::default_mem_latency
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          redirect_valid,
    input  logic [ifetch_pkg::addr_w-1:0] redirect_pc,
    output logic                          instr_valid,
    output logic [ifetch_pkg::addr_w-1:0] instr_pc,
    output logic [ifetch_pkg::data_w-1:0] instr
);

    cpu_cache_if cpu_bus ();
    cache_mem_if mem_bus ();

    fetch_unit #(
        .mem_words (mem_words)
    ) fetch_unit_inst (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .req            (cpu_bus.requester),
        .instr_valid    (instr_valid),
        .instr_pc       (instr_pc),
        .instr          (instr)
    );

    icache #(
        .lines     (lines),
        .mem_words (mem_words)
    ) icache_inst (
        .clk (clk),
        .rst (rst),
        .cpu (cpu_bus.responder),
        .mem (mem_bus.requester)
    );

    instr_mem #(
        .mem_words   (mem_words),
        .mem_latency (mem_latency)
    ) instr_mem_inst (
        .clk  (clk),
        .rst  (rst),
        .port (mem_bus.responder)
    );

endmodule

// File: src/instr_mem.sv
module instr_mem #(
    parameter int mem_words   = ifetch_pkg::default_mem_words,
    parameter int mem_latency = ifetch_pkg::default_mem_latency
) (
    input  logic           clk,
    input  logic           rst,
    cache_mem_if.responder port
);

    localparam int idx_w = $clog2(mem_words);
    localparam int cnt_w = $clog2(mem_latency + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(mem_latency);

    logic [ifetch_pkg::data_w-1:0] rom [mem_words];

    logic             busy;
    logic [cnt_w-1:0] cnt;
    logic [idx_w-1:0] word_idx;
    logic             accept;

    initial
    begin
        $readmemh("program.hex", rom);
    end

    assign accept     = port.valid && !busy;
    assign port.ready = busy && (cnt == cnt_last);
    assign port.data  = rom[word_idx];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            cnt  <= '0;
        end
        else if (accept)
        begin
            busy <= 1'b1;
            cnt  <= 1; // the cycle after acceptance counts as the first.
        end
        else if (port.ready)
            busy <= 1'b0;
        else if (busy)
            cnt <= cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            word_idx <= port.addr[idx_w+1:2];
    end

    // while counting, the only request on the port is the one being served.
    assert property (@(posedge clk) disable iff (rst)
        busy |-> port.valid && (port.addr[idx_w+1:2] == word_idx));

endmodule

// File: src/icache.sv
module icache #(
    parameter int lines     = ifetch_pkg::default_lines,
    parameter int mem_words = ifetch_pkg::default_mem_words
) (
    input  logic            clk,
    input  logic            rst,
    cpu_cache_if.responder  cpu,
    cache_mem_if.requester  mem
);

    localparam int idx_w     = $clog2(lines);
    localparam int mem_idx_w = $clog2(mem_words);
    localparam int tag_w     = mem_idx_w - idx_w; // addresses past the ROM alias onto it.

    ifetch_pkg::cache_state_t state;
    ifetch_pkg::cache_state_t state_next;

    logic [lines-1:0]              line_valid;
    logic [tag_w-1:0]              tag_arr  [lines];
    logic [ifetch_pkg::data_w-1:0] data_arr [lines];

    logic [idx_w-1:0] index;
    logic [tag_w-1:0] tag;
    logic             hit;
    logic             refill;

    assign index  = cpu.addr[idx_w+1:2];
    assign tag    = cpu.addr[mem_idx_w+1:idx_w+2];
    assign hit    = line_valid[index] && (tag_arr[index] == tag);
    assign refill = (state == ifetch_pkg::allocate) && mem.ready;

    assign cpu.ready = (state == ifetch_pkg::compare_tag) && hit;
    assign cpu.data  = data_arr[index];

    // the miss is requested straight from compare_tag to save a cycle.
    assign mem.valid = ((state == ifetch_pkg::compare_tag) && !hit)
                     || (state == ifetch_pkg::allocate);
    assign mem.addr  = {cpu.addr[ifetch_pkg::addr_w-1:2], 2'b00};

    always_comb
    begin
        state_next = state;
        case (state)
            ifetch_pkg::idle:
                if (cpu.valid)
                    state_next = ifetch_pkg::compare_tag;
            ifetch_pkg::compare_tag:
                state_next = hit ? ifetch_pkg::idle : ifetch_pkg::allocate;
            ifetch_pkg::allocate:
                if (mem.ready)
                    state_next = ifetch_pkg::compare_tag; // looks up again and hits.
            default:
                state_next = ifetch_pkg::idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= ifetch_pkg::idle;
            line_valid <= '0;
        end
        else
        begin
            state <= state_next;
            if (refill)
                line_valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (refill)
        begin
            tag_arr[index]  <= tag;
            data_arr[index] <= mem.data;
        end
    end

    // a hit is only ever reported against a live request.
    assert property (@(posedge clk) disable iff (rst)
        cpu.ready |-> cpu.valid && (state == ifetch_pkg::compare_tag));

    assert property (@(posedge clk) disable iff (rst)
        mem.valid && !mem.ready |=> mem.valid && $stable(mem.addr));

    // the fetch unit must hold its address until the answer comes back.
    assert property (@(posedge clk) disable iff (rst)
        cpu.valid && !cpu.ready |=> $stable(cpu.addr));

endmodule

// File: src/fetch_unit.sv
module fetch_unit #(
    parameter int mem_words = ifetch_pkg::default_mem_words
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          redirect_valid,
    input  logic [ifetch_pkg::addr_w-1:0] redirect_pc,
    cpu_cache_if.requester                req,
    output logic                          instr_valid,
    output logic [ifetch_pkg::addr_w-1:0] instr_pc,
    output logic [ifetch_pkg::data_w-1:0] instr
);

    localparam logic [ifetch_pkg::addr_w-1:0] pc_mask = mem_words * 4 - 1;

    ifetch_pkg::fetch_state_t      state;
    logic                          redirect_pending;
    logic [ifetch_pkg::addr_w-1:0] redirect_target;
    logic [ifetch_pkg::addr_w-1:0] next_pc;
    logic                          done;

    assign done = (state == ifetch_pkg::fetching) && req.ready;

    // a redirect in the completing cycle itself takes effect at once.
    always_comb
    begin
        if (redirect_valid)
            next_pc = {redirect_pc[ifetch_pkg::addr_w-1:2], 2'b00};
        else if (redirect_pending)
            next_pc = redirect_target;
        else
            next_pc = (req.addr + 4) & pc_mask; // wraps at the end of the ROM.
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state            <= ifetch_pkg::reset_wait;
            req.valid        <= 1'b0;
            req.addr         <= '0;
            instr_valid      <= 1'b0;
            redirect_pending <= 1'b0;
        end
        else
        begin
            instr_valid <= done;
            if (state == ifetch_pkg::reset_wait)
            begin
                state     <= ifetch_pkg::fetching;
                req.valid <= 1'b1; // first request goes out at pc 0.
            end
            if (done)
            begin
                req.addr         <= next_pc;
                redirect_pending <= 1'b0;
            end
            else if (redirect_valid)
                redirect_pending <= 1'b1; // held until the fetch in flight returns.
        end
    end

    always_ff @(posedge clk)
    begin
        if (redirect_valid)
            redirect_target <= {redirect_pc[ifetch_pkg::addr_w-1:2], 2'b00};
        if (done)
        begin
            instr_pc <= req.addr;
            instr    <= req.data;
        end
    end

endmodule

// File: src/fetch_ifs.sv
interface cpu_cache_if;

    logic [ifetch_pkg::addr_w-1:0] addr;
    logic                          valid; // held until ready.
    logic [ifetch_pkg::data_w-1:0] data;
    logic                          ready; // one-cycle strobe, data valid with it.

    modport requester (
        output addr,
        output valid,
        input  data,
        input  ready
    );

    modport responder (
        input  addr,
        input  valid,
        output data,
        output ready
    );

endinterface

interface cache_mem_if;

    logic [ifetch_pkg::addr_w-1:0] addr;
    logic                          valid;
    logic [ifetch_pkg::data_w-1:0] data;
    logic                          ready;

    modport requester (
        output addr,
        output valid,
        input  data,
        input  ready
    );

    modport responder (
        input  addr,
        input  valid,
        output data,
        output ready
    );

endinterface

// File: src/ifetch_pkg.sv
package ifetch_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;

    localparam int default_lines       = 8;
    localparam int default_mem_words   = 64;
    localparam int default_mem_latency = 3; // cycles from accepted request to ready.

    // icache sequencing: look up, then refill on a miss.
    typedef enum logic [1:0] {
        idle,
        compare_tag,
        allocate
    } cache_state_t;

    typedef enum logic {
        reset_wait,
        fetching
    } fetch_state_t;

endpackage
